// File: audio_capture.f
rtl/audio_capture_pkg.sv
rtl/i2s_clk_gen.sv
rtl/i2s_rx.sv
rtl/sample_arbiter.sv
rtl/sample_buffer.sv
rtl/audio_capture_top.sv
verification/tb_audio_capture.sv

// File: Bender.yml
package:
  name: audio_capture

sources:
  - rtl/audio_capture_pkg.sv
  - rtl/i2s_clk_gen.sv
  - rtl/i2s_rx.sv
  - rtl/sample_arbiter.sv
  - rtl/sample_buffer.sv
  - rtl/audio_capture_top.sv
  - target: test
    files:
      - verification/tb_audio_capture.sv

// File: verification/audio_capture_vectors.txt
# port(0,1,2=both) pdm ddr lsb sample_word div0 div1 bits_word ws_time ws_value ws_fix
#   nwords drain tx0 tx1 exp0 exp1 (words in hex, port 1 carries tx1 on channel 0)
0 0 0 0 1 1 1 15 0 0 0 1 1 00001234 0000A5F0 00001234 0000A5F0
0 0 0 1 1 1 1 15 0 0 0 1 1 00001234 0000A5F0 2C480000 0FA50000
1 1 0 0 0 2 2 15 5 0 0 2 1 DEADBEEF 13579BDF DEADBEEF 13579BDF
0 1 1 0 0 2 2 15 5 0 0 2 1 CAFEF00D 0F1E2D3C CAFEF00D 0F1E2D3C
1 0 0 0 0 1 1 15 0 1 1 1 1 89ABCDEF 76543210 89ABCDEF 76543210
2 0 0 0 0 1 3 15 7 0 0 3 1 A1B2C3D4 5E6F7081 A1B2C3D4 5E6F7081
0 0 0 0 0 0 0 15 3 0 0 9 0 3C3C5A5A 0FF0F00F 3C3C5A5A 0FF0F00F

// File: verification/tb_audio_capture.sv
module tb_audio_capture;

    timeunit 1ns;
    timeprecision 1ps;

    import audio_capture_pkg::*;

    localparam int TIMEOUT = 20000;   // cycles per wait

    logic                    clk_i;
    logic                    rstn_i;
    i2s_cfg_t                cfg [NUM_PORTS];
    logic [NUM_CHANNELS-1:0] sd  [NUM_PORTS];
    logic [NUM_PORTS-1:0]    sck;
    logic [NUM_PORTS-1:0]    ws;
    logic                    rd_en;
    sample_entry_t           rd_data;
    logic                    rd_valid;
    logic                    empty;
    buf_level_t              level;
    logic                    overflow;
    logic [NUM_PORTS-1:0]    drop;

    int            errors;
    int            timeouts;
    logic          drain_on;
    logic          mon_on     [NUM_PORTS];
    logic          ws_end     [NUM_PORTS];   // ws level when the stream ended
    int            ws_toggles [NUM_PORTS];
    logic          ws_prev    [NUM_PORTS];
    logic          drop_seen  [NUM_PORTS];
    sample_entry_t got0 [$];   // entries read back from port 0
    sample_entry_t got1 [$];

    audio_capture_top u_dut (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .port0_cfg_i(cfg[0]),
        .port1_cfg_i(cfg[1]),
        .port0_sd_i (sd[0]),
        .port1_sd_i (sd[1]),
        .port0_sck_o(sck[0]),
        .port0_ws_o (ws[0]),
        .port1_sck_o(sck[1]),
        .port1_ws_o (ws[1]),
        .rd_en_i    (rd_en),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .empty_o    (empty),
        .level_o    (level),
        .overflow_o (overflow),
        .drop_o     (drop)
    );

    always #2 clk_i = ~clk_i;

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t ns: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // one data bit per channel from the same position of each word
    function automatic logic [1:0] next_bits(input sample_t w0, input sample_t w1, input int idx);
        return {w1[idx], w0[idx]};
    endfunction

    // later 32 bit words carry an offset so that order and discarded words show
    function automatic sample_t word_mask(input int wi, input int nbits, input logic rev);
        sample_t m;
        sample_t r;
        m = (nbits == 32) ? sample_t'(wi) * 32'h0101_0101 : '0;
        for (int b = 0; b < 32; b++)
            r[b] = m[31 - b];
        return rev ? r : m;
    endfunction

    // host drain with one read strobe every other cycle
    always
    begin
        @(posedge clk_i);
        #0.5;
        if (rd_valid)
        begin
            if (rd_data.port == 0)
                got0.push_back(rd_data);
            else
                got1.push_back(rd_data);
        end
        rd_en = drain_on && !rd_en && !empty;
    end

    // ws may only change while sck is low
    always
    begin
        @(posedge clk_i);
        #0.5;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (drop[p])
                drop_seen[p] = 1'b1;
            if (mon_on[p] && (ws[p] !== ws_prev[p]))
            begin
                ws_toggles[p]++;
                check_val(sck[p], 0, $sformatf("port %0d ws changed with sck high", p));
            end
            ws_prev[p] = ws[p];
        end
    end

    task automatic apply_reset();
        drain_on = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            cfg[p] = '0;
            sd[p]  = '0;
        end
        rstn_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #0.5;
        rstn_i = 1'b1;
        @(posedge clk_i);
        #0.5;
        check_val(sck, 0, "sck after reset");
        check_val(ws, 0, "ws after reset");
        check_val(rd_valid, 0, "rd_valid after reset");
        check_val(overflow, 0, "overflow after reset");
        check_val(drop, 0, "drop after reset");
        check_val(empty, 1, "empty after reset");
    endtask

    // SDR bits change after a fall and DDR bits after every edge
    task automatic send_stream(input int p, input int nbits, input int nwords, input logic ddr,
                               input sample_t w0, input sample_t w1);
        int      total;
        int      k;
        int      guard;
        logic    prev;
        logic    now;
        sample_t m;
        total = nbits * nwords;
        k     = 0;
        guard = 0;
        sd[p] = next_bits(w0, w1, nbits - 1);
        prev  = sck[p];
        while (k < total && guard < TIMEOUT)
        begin
            @(posedge clk_i);
            #0.5;
            guard++;
            now = sck[p];
            if (now !== prev)
            begin
                if (ddr || now)
                    k++;        // bit taken by the receiver
                if ((ddr || !now) && k < total)
                begin
                    m     = word_mask(k / nbits, nbits, 1'b0);
                    sd[p] = next_bits(w0 ^ m, w1 ^ m, nbits - 1 - (k % nbits));
                end
            end
            prev = now;
        end
        while (!ddr && sck[p] && guard < TIMEOUT)
        begin
            @(posedge clk_i);
            #0.5;
            guard++;
        end
        @(posedge clk_i);
        #0.5;
        mon_on[p] = 1'b0;
        ws_end[p] = ws[p];
        // the last burst has left the receiver before it is switched off
        repeat (NUM_CHANNELS) @(posedge clk_i);
        #0.5;
        cfg[p].enable = 1'b0;
        if (guard >= TIMEOUT)
        begin
            timeouts++;
            $display("timeout: port %0d transmitter stalled after %0d of %0d bits", p, k, total);
        end
    endtask

    task automatic wait_count(input logic [NUM_PORTS-1:0] act, input int total);
        int guard;
        guard = 0;
        while (((act[0] && got0.size() < total) || (act[1] && got1.size() < total))
               && guard < TIMEOUT)
        begin
            @(posedge clk_i);
            #0.5;
            guard++;
        end
        if (guard >= TIMEOUT)
        begin
            timeouts++;
            $display("timeout: buffer never returned %0d entries per active port", total);
        end
    endtask

    task automatic check_port(input int p, input int nwords, input int nbits, input logic lsb,
                              input sample_t ea, input sample_t eb);
        sample_entry_t e;
        int            n;
        sample_t       want;
        n = (p == 0) ? got0.size() : got1.size();
        check_val(n, nwords * NUM_CHANNELS, $sformatf("entry count on port %0d", p));
        for (int i = 0; i < n && i < nwords * NUM_CHANNELS; i++)
        begin
            e    = (p == 0) ? got0[i] : got1[i];
            want = ((i % NUM_CHANNELS == 0) ? ea : eb)
                   ^ word_mask(i / NUM_CHANNELS, nbits, lsb);
            check_val(e.chan, i % NUM_CHANNELS, $sformatf("port %0d entry %0d channel", p, i));
            check_val(e.data, want, $sformatf("port %0d entry %0d sample", p, i));
        end
    endtask

    task automatic run_record(input int port, input int pdm, input int ddr, input int lsb,
                              input int sword, input int div0, input int div1, input int bw,
                              input int wst, input int wsv, input int wsf, input int nwords,
                              input int drain, input sample_t tx0, input sample_t tx1,
                              input sample_t ex0, input sample_t ex1);
        logic [NUM_PORTS-1:0] act;
        int                   nbits;
        int                   guard;
        act   = (port == 2) ? 2'b11 : ((port == 1) ? 2'b10 : 2'b01);
        nbits = (sword != 0 && pdm == 0) ? bw + 1 : 32;
        apply_reset();
        got0.delete();
        got1.delete();
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            ws_toggles[p] = 0;
            ws_prev[p]    = ws[p];
            drop_seen[p]  = 1'b0;
            mon_on[p]     = act[p];
            if (act[p])
            begin
                cfg[p].pdm_en      = pdm[0];
                cfg[p].pdm_ddr     = ddr[0];
                cfg[p].lsbfirst    = lsb[0];
                cfg[p].sample_word = sword[0];
                cfg[p].clk_div     = clk_div_t'((p == 0) ? div0 : div1);
                cfg[p].bits_word   = bit_count_t'(bw);
                cfg[p].ws_time     = bit_count_t'(wst);
                cfg[p].ws_value    = wsv[0];
                cfg[p].ws_fix      = wsf[0];
                cfg[p].enable      = 1'b1;
            end
        end
        drain_on = drain[0];
        fork
            begin
                if (act[0])
                    send_stream(0, nbits, nwords, ddr[0], tx0, tx1);
            end
            begin
                if (act[1])
                    send_stream(1, nbits, nwords, ddr[0], tx1, tx0);  // channels swapped
            end
        join
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (act[p] && wsf != 0)
                check_val(ws_end[p], wsv, $sformatf("port %0d fixed ws level", p));
            else if (act[p])
                check_val(ws_toggles[p], nwords, $sformatf("port %0d ws toggles", p));
        end
        if (drain != 0)
        begin
            wait_count(act, nwords * NUM_CHANNELS);
            cfg[0].enable = 1'b0;
            cfg[1].enable = 1'b0;
            drain_on      = 1'b0;
            if (act[0])
                check_port(0, nwords, nbits, lsb[0], ex0, ex1);
            if (act[1])
                check_port(1, nwords, nbits, lsb[0], ex1, ex0);
            check_val(overflow, 0, "overflow while draining");
            check_val({drop_seen[1], drop_seen[0]}, 0, "drop while draining");
        end
        else
        begin
            guard = 0;
            while ((level != buf_level_t'(BUF_DEPTH) || !overflow) && guard < TIMEOUT)
            begin
                @(posedge clk_i);
                #0.5;
                guard++;
            end
            if (guard >= TIMEOUT)
            begin
                timeouts++;
                $display("timeout: buffer did not fill up and flag overflow");
            end
            check_val(level, BUF_DEPTH, "saturated fill level");
            cfg[0].enable = 1'b0;
            drain_on      = 1'b1;
            wait_count(act, BUF_DEPTH);
            drain_on      = 1'b0;
            check_port(0, BUF_DEPTH / NUM_CHANNELS, nbits, lsb[0], ex0, ex1);
            check_val(overflow, 1, "overflow after drain");
        end
        repeat (4) @(posedge clk_i);
        #0.5;
    endtask

    initial
    begin
        int      fd;
        int      n;
        string   line;
        int      f [13];
        sample_t w [4];
        clk_i    = 1'b0;
        rstn_i   = 1'b0;
        rd_en    = 1'b0;
        drain_on = 1'b0;
        errors   = 0;
        timeouts = 0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            cfg[p]    = '0;
            sd[p]     = '0;
            mon_on[p] = 1'b0;
        end
        fd = $fopen("verification/audio_capture_vectors.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the vector file verification/audio_capture_vectors.txt");
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], w[0], w[1], w[2], w[3]);
                if (n != 17)
                begin
                    errors++;
                    $display("malformed vector line: %s", line);
                    continue;
                end
                run_record(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                           f[10], f[11], f[12], w[0], w[1], w[2], w[3]);
            end
            $fclose(fd);
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: rtl/audio_capture_top.sv
module audio_capture_top (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  audio_capture_pkg::i2s_cfg_t                port0_cfg_i,
    input  audio_capture_pkg::i2s_cfg_t                port1_cfg_i,
    input  logic [audio_capture_pkg::NUM_CHANNELS-1:0] port0_sd_i,
    input  logic [audio_capture_pkg::NUM_CHANNELS-1:0] port1_sd_i,
    output logic                                       port0_sck_o,
    output logic                                       port0_ws_o,
    output logic                                       port1_sck_o,
    output logic                                       port1_ws_o,
    input  logic                                       rd_en_i,
    output audio_capture_pkg::sample_entry_t           rd_data_o,
    output logic                                       rd_valid_o,
    output logic                                       empty_o,
    output audio_capture_pkg::buf_level_t              level_o,
    output logic                                       overflow_o,
    output logic [audio_capture_pkg::NUM_PORTS-1:0]    drop_o
);

    import audio_capture_pkg::*;

    logic [NUM_PORTS-1:0]       rx_valid;
    rx_sample_t [NUM_PORTS-1:0] rx_sample;   // indexed by port
    logic                       wr_en;
    sample_entry_t              wr_entry;

    i2s_rx u_rx0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_i         (port0_cfg_i),
        .sd_i          (port0_sd_i),
        .sck_o         (port0_sck_o),
        .ws_o          (port0_ws_o),
        .sample_valid_o(rx_valid[0]),
        .sample_o      (rx_sample[0])
    );

    i2s_rx u_rx1 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_i         (port1_cfg_i),
        .sd_i          (port1_sd_i),
        .sck_o         (port1_sck_o),
        .ws_o          (port1_ws_o),
        .sample_valid_o(rx_valid[1]),
        .sample_o      (rx_sample[1])
    );

    sample_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .valid_i   (rx_valid),
        .sample_i  (rx_sample),
        .wr_en_o   (wr_en),
        .wr_entry_o(wr_entry),
        .drop_o    (drop_o)
    );

    // shared sample memory, drained by the host
    sample_buffer u_buffer (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_en_i   (wr_en),
        .wr_entry_i(wr_entry),
        .rd_en_i   (rd_en_i),
        .rd_data_o (rd_data_o),
        .rd_valid_o(rd_valid_o),
        .empty_o   (empty_o),
        .level_o   (level_o),
        .overflow_o(overflow_o)
    );

endmodule

// File: rtl/sample_buffer.sv
module sample_buffer (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               wr_en_i,
    input  audio_capture_pkg::sample_entry_t   wr_entry_i,
    input  logic                               rd_en_i,
    output audio_capture_pkg::sample_entry_t   rd_data_o,
    output logic                               rd_valid_o,
    output logic                               empty_o,
    output audio_capture_pkg::buf_level_t      level_o,
    output logic                               overflow_o
);

    import audio_capture_pkg::*;

    sample_entry_t     mem [BUF_DEPTH];
    logic [BUF_AW-1:0] wr_ptr;
    logic [BUF_AW-1:0] rd_ptr;
    buf_level_t        level;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    assign full    = (level == buf_level_t'(BUF_DEPTH));
    assign empty_o = (level == '0);
    assign level_o = level;
    assign do_wr   = wr_en_i && !full;    // writes into a full buffer are lost
    assign do_rd   = rd_en_i && !empty_o;

    always_ff @(posedge clk_i)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_entry_i;
        if (do_rd)
            rd_data_o <= mem[rd_ptr];
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            rd_valid_o <= 1'b0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                level <= level + 1'b1;
            else if (do_rd && !do_wr)
                level <= level - 1'b1;
            rd_valid_o <= do_rd;
            if (wr_en_i && full)
                overflow_o <= 1'b1;   // sticky
        end
    end

    a_level_max: assert property (@(posedge clk_i) disable iff (!rstn_i)
        level <= buf_level_t'(BUF_DEPTH))
        else $error("sample_buffer: fill level above BUF_DEPTH");

endmodule

// File: rtl/sample_arbiter.sv
module sample_arbiter (
    input  logic                                                         clk_i,
    input  logic                                                         rstn_i,
    input  logic [audio_capture_pkg::NUM_PORTS-1:0]                      valid_i,
    input  audio_capture_pkg::rx_sample_t [audio_capture_pkg::NUM_PORTS-1:0] sample_i,
    output logic                                                         wr_en_o,
    output audio_capture_pkg::sample_entry_t                             wr_entry_o,
    output logic [audio_capture_pkg::NUM_PORTS-1:0]                      drop_o
);

    import audio_capture_pkg::*;

    rx_sample_t          q_mem [NUM_PORTS][QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] q_wr  [NUM_PORTS];
    logic [QUEUE_AW-1:0] q_rd  [NUM_PORTS];
    logic [QUEUE_AW:0]   q_cnt [NUM_PORTS];

    logic [NUM_PORTS-1:0] full;
    logic [NUM_PORTS-1:0] push;
    logic [NUM_PORTS-1:0] grant;
    port_idx_t            gnt_idx;
    port_idx_t            last_q;   // port granted most recently
    rx_sample_t           head;

    always_comb
    begin
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            full[p] = (q_cnt[p] == (QUEUE_AW + 1)'(QUEUE_DEPTH));
            push[p] = valid_i[p] && !full[p];
        end
    end

    // round robin, search starts after the last winner
    always_comb
    begin
        int   idx;
        logic found;
        grant   = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++)
        begin
            idx = (int'(last_q) + k) % NUM_PORTS;
            if (!found && (q_cnt[idx] != '0))
            begin
                grant[idx] = 1'b1;
                gnt_idx    = port_idx_t'(idx);
                found      = 1'b1;
            end
        end
    end

    assign head    = q_mem[gnt_idx][q_rd[gnt_idx]];
    assign wr_en_o = |grant;

    always_comb
    begin
        wr_entry_o.port = gnt_idx;
        wr_entry_o.chan = head.chan;
        wr_entry_o.data = head.data;
    end

    always_ff @(posedge clk_i)
    begin
        for (int p = 0; p < NUM_PORTS; p++)
            if (push[p])
                q_mem[p][q_wr[p]] <= sample_i[p];
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                q_wr[p]  <= '0;
                q_rd[p]  <= '0;
                q_cnt[p] <= '0;
            end
            last_q <= '0;
            drop_o <= '0;
        end
        else
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (push[p])
                    q_wr[p] <= q_wr[p] + 1'b1;
                if (grant[p])
                    q_rd[p] <= q_rd[p] + 1'b1;
                case ({push[p], grant[p]})
                    2'b10:   q_cnt[p] <= q_cnt[p] + 1'b1;
                    2'b01:   q_cnt[p] <= q_cnt[p] - 1'b1;
                    default: q_cnt[p] <= q_cnt[p];
                endcase
            end
            drop_o <= valid_i & full;   // one cycle per lost sample
            if (|grant)
                last_q <= gnt_idx;
        end
    end

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_en_o |-> $onehot(grant))
        else $error("sample_arbiter: grant not one-hot");

endmodule

// File: rtl/i2s_rx.sv
module i2s_rx (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  audio_capture_pkg::i2s_cfg_t                cfg_i,
    input  logic [audio_capture_pkg::NUM_CHANNELS-1:0] sd_i,
    output logic                                       sck_o,
    output logic                                       ws_o,
    output logic                                       sample_valid_o,
    output audio_capture_pkg::rx_sample_t              sample_o
);

    import audio_capture_pkg::*;

    logic       rise;
    logic       fall;
    logic       shift;
    logic       packed_mode;
    logic       shift_pack;
    logic       word_done;
    bit_count_t bit_cnt;           // bits of the current word
    bit_count_t pack_cnt;          // bits toward a 32 bit packed sample
    bit_count_t active_cnt;
    chan_idx_t  chan_idx;
    logic       running;

    sample_t shreg     [NUM_CHANNELS];
    sample_t shreg_nxt [NUM_CHANNELS];
    sample_t hold      [NUM_CHANNELS];

    i2s_clk_gen u_clk_gen (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .en_i     (cfg_i.enable),
        .clk_div_i(cfg_i.clk_div),
        .clk_o    (sck_o),
        .rise_o   (rise),
        .fall_o   (fall)
    );

    // ddr only applies in pdm mode
    assign shift       = (cfg_i.pdm_en && cfg_i.pdm_ddr) ? (rise | fall) : rise;
    assign packed_mode = cfg_i.pdm_en || !cfg_i.sample_word;
    assign shift_pack  = packed_mode && shift;
    assign active_cnt  = packed_mode ? pack_cnt : bit_cnt;

    // last bit of a word lands on this shift pulse
    assign word_done = packed_mode ? (shift_pack && (pack_cnt == 6'd31))
                                   : (shift && (bit_cnt == cfg_i.bits_word));

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            bit_cnt  <= '0;
            pack_cnt <= '0;
        end
        else if (!cfg_i.enable)
        begin
            bit_cnt  <= '0;
            pack_cnt <= '0;
        end
        else
        begin
            if (shift)
                bit_cnt <= (bit_cnt == cfg_i.bits_word) ? '0 : bit_cnt + 1'b1;
            if (shift_pack)
                pack_cnt <= (pack_cnt == 6'd31) ? '0 : pack_cnt + 1'b1;
        end
    end

    always_comb
    begin
        for (int c = 0; c < NUM_CHANNELS; c++)
        begin
            if (cfg_i.lsbfirst)
                shreg_nxt[c] = {sd_i[c], shreg[c][31:1]};
            else
                shreg_nxt[c] = {shreg[c][30:0], sd_i[c]};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
                shreg[c] <= '0;
        end
        else
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
            begin
                if (!cfg_i.enable)
                    shreg[c] <= '0;
                else if (shift)
                    shreg[c] <= shreg_nxt[c];
            end
        end
    end

    // snapshot at word end, the shift registers may move on during the burst
    always_ff @(posedge clk_i)
    begin
        if (word_done)
        begin
            for (int c = 0; c < NUM_CHANNELS; c++)
                hold[c] <= shreg_nxt[c];
        end
    end

    // output burst, one channel per cycle
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            running  <= 1'b0;
            chan_idx <= '0;
        end
        else if (!cfg_i.enable)
        begin
            running  <= 1'b0;
            chan_idx <= '0;
        end
        else if (word_done)
        begin
            running  <= 1'b1;
            chan_idx <= '0;
        end
        else if (running)
        begin
            if (chan_idx == chan_idx_t'(NUM_CHANNELS - 1))
            begin
                running  <= 1'b0;
                chan_idx <= '0;
            end
            else
            begin
                chan_idx <= chan_idx + 1'b1;
            end
        end
    end

    assign sample_valid_o = running;

    always_comb
    begin
        sample_o.chan = chan_idx;
        sample_o.data = hold[chan_idx];
    end

    // word select, changes only with a falling sck
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            ws_o <= 1'b0;
        else if (!cfg_i.enable)
            ws_o <= 1'b0;
        else if (cfg_i.ws_fix)
            ws_o <= cfg_i.ws_value;
        else if (fall && (active_cnt == cfg_i.ws_time))
            ws_o <= ~ws_o;
    end

    // a burst ends after one cycle per channel
    a_burst_len: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(sample_valid_o) |-> ##NUM_CHANNELS !sample_valid_o)
        else $error("i2s_rx: sample_valid longer than NUM_CHANNELS cycles");

endmodule

// File: rtl/i2s_clk_gen.sv
module i2s_clk_gen (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        en_i,
    input  audio_capture_pkg::clk_div_t clk_div_i,
    output logic                        clk_o,
    output logic                        rise_o,
    output logic                        fall_o
);

    import audio_capture_pkg::*;

    clk_div_t cnt;
    logic     toggle;

    // >= keeps the divider sane if clk_div shrinks while running
    assign toggle = en_i && (cnt >= clk_div_i);

    // pulses mark the cycle in which clk_o changes
    assign rise_o = toggle && !clk_o;
    assign fall_o = toggle && clk_o;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cnt   <= '0;
            clk_o <= 1'b0;
        end
        else if (!en_i)
        begin
            cnt   <= '0;       // idle low
            clk_o <= 1'b0;
        end
        else if (toggle)
        begin
            cnt   <= '0;
            clk_o <= ~clk_o;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: rtl/audio_capture_pkg.sv
package audio_capture_pkg;

    // receiver and buffer dimensions
    localparam int NUM_CHANNELS = 2;    // serial data lines per receiver
    localparam int NUM_PORTS    = 2;    // receivers sharing the buffer
    localparam int CHAN_W       = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;
    localparam int PORT_W       = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int BUF_DEPTH    = 16;
    localparam int BUF_AW       = $clog2(BUF_DEPTH);
    localparam int QUEUE_DEPTH  = 4;    // holding entries per port
    localparam int QUEUE_AW     = $clog2(QUEUE_DEPTH);

    typedef logic [31:0]       sample_t;
    typedef logic [10:0]       clk_div_t;
    typedef logic [5:0]        bit_count_t;
    typedef logic [CHAN_W-1:0] chan_idx_t;
    typedef logic [PORT_W-1:0] port_idx_t;
    typedef logic [BUF_AW:0]   buf_level_t;  // 0 .. BUF_DEPTH

    // one receiver's configuration
    typedef struct packed {
        logic       enable;
        logic       pdm_en;
        logic       pdm_ddr;       // shift on both sck edges in pdm mode
        logic       lsbfirst;
        logic       sample_word;   // 1: one sample per word, 0: packed 32 bit
        clk_div_t   clk_div;
        bit_count_t bits_word;     // word length minus one
        bit_count_t ws_time;       // bit count at which ws toggles
        logic       ws_value;
        logic       ws_fix;
    } i2s_cfg_t;

    // receiver output, one channel per cycle
    typedef struct packed {
        chan_idx_t chan;
        sample_t   data;
    } rx_sample_t;

    // entry stored in the shared buffer
    typedef struct packed {
        port_idx_t port;
        chan_idx_t chan;
        sample_t   data;
    } sample_entry_t;

endpackage
